//--- list.f
design/cipher_pkg.sv
design/seg_encoder.sv
design/display_select.sv
design/perf_counters.sv
design/mac_column_array.sv
design/cipher_sequencer.sv
design/cipher_top.sv
verification/tb_cipher_top.sv

//--- Makefile
# Verilator build and run for the matrix cipher testbench

TOP := tb_cipher_top

.PHONY: all sim lint clean

all: sim

obj_dir/V$(TOP): list.f $(shell cat list.f)
	verilator --binary --timing -f list.f --top-module $(TOP) -o V$(TOP)

sim: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^Result: PASSED$$"

lint:
	verilator --lint-only -Wall --timing -f list.f --top-module $(TOP)

clean:
	rm -rf obj_dir

//--- verification/tb_cipher_top.sv
// Testbench for the cipher top level
// Steps the display mode with button presses from a table and checks
// all six segment digits after each step

`timescale 1ns/1ps

module tb_cipher_top;
    import cipher_pkg::*;

    // ----------------------------------------
    // Timing
    // ----------------------------------------
    localparam int clk_period    = 4;    // ns
    localparam int reset_cycles  = 16;
    localparam int settle_cycles = 8;    // Idle after release, before the check
    localparam int short_press   = 4;
    localparam int long_press    = 20;
    localparam int result_wait   = 200;  // Well past the start-up delay
    localparam int n_rows        = 7;
    localparam int run_cycles    = reset_cycles + init_delay + result_wait
                                 + n_rows * (long_press + settle_cycles) + 100;

    // ----------------------------------------
    // Segment shapes, active low
    // ----------------------------------------
    localparam seg_t seg_c = 7'b1000110;
    localparam seg_t seg_e = 7'b0000110;
    localparam seg_t seg_h = 7'b0001001;
    localparam seg_t seg_i = 7'b1111001;
    localparam seg_t seg_j = 7'b1100001;
    localparam seg_t seg_k = 7'b0001001;  // Same shape as H
    localparam seg_t seg_o = 7'b1000000;
    localparam seg_t seg_p = 7'b0001100;
    localparam seg_t seg_r = 7'b0101111;
    localparam seg_t seg_u = 7'b1000001;
    localparam seg_t seg_x = 7'b0001001;  // Same shape as H

    // Hex digits
    localparam seg_t seg_0 = 7'b1000000;
    localparam seg_t seg_2 = 7'b0100100;
    localparam seg_t seg_8 = 7'b0000000;

    // Concatenations list hex5 first
    localparam display_t disp_plain  = '{digit: {seg_r, seg_e, seg_h, seg_p, seg_i, seg_c}};
    localparam display_t disp_cipher = '{digit: {seg_h, seg_u, seg_j, seg_x, seg_o, seg_k}};
    localparam display_t disp_ops    = '{digit: {seg_p, seg_o, seg_0, seg_2, seg_0, seg_0}};
    localparam display_t disp_cycles = '{digit: {seg_c, seg_c, seg_0, seg_0, seg_0, seg_8}};

    typedef struct packed {
        logic [15:0] idle;      // Cycles before the press
        logic [15:0] hold;      // Press length, 0 for none
        display_t    expected;
    } table_row_t;

    table_row_t rows [n_rows];

    logic     clk_clk;
    logic     reset_reset_n;
    logic     mode_button;
    display_t hex;

    cipher_top i_dut (
        .clk_clk       (clk_clk),
        .reset_reset_n (reset_reset_n),
        .mode_button   (mode_button),
        .hex           (hex)
    );

    initial begin
        clk_clk = 1'b0;
        forever #(clk_period / 2) clk_clk = ~clk_clk;
    end

    // ----------------------------------------
    // Helpers
    // ----------------------------------------
    task automatic stop_on_error();
        $display("Result: FAILED");
        $fatal(1, "Stopped at the first failure");
    endtask

    // Advance n cycles, landing just after the rising edge
    task automatic next_cycles(input int n);
        repeat (n) begin
            @(posedge clk_clk);
            #1;
        end
    endtask

    task automatic press_button(input int len);
        mode_button = 1'b1;
        next_cycles(len);
        mode_button = 1'b0;
    endtask

    task automatic check_display(input int r);
        for (int n = 0; n < word_len; n++) begin
            assert (hex.digit[n] === rows[r].expected.digit[n])
            else begin
                $display("ERROR row %0d hex.digit[%0d]: got 0x%02h, expected 0x%02h",
                         r, n, hex.digit[n], rows[r].expected.digit[n]);
                stop_on_error();
            end
        end
    endtask

    // ----------------------------------------
    // Stimulus table and main sequence
    // ----------------------------------------
    initial begin
        mode_button   = 1'b0;
        reset_reset_n = 1'b0;

        rows[0] = '{idle: 16'd8, hold: 16'd0, expected: disp_plain};  // Straight after reset
        rows[1] = '{idle: 16'd2, hold: 16'(short_press), expected: disp_plain};  // Still starting
        rows[2] = '{idle: 16'(result_wait), hold: 16'(short_press), expected: disp_cipher};
        rows[3] = '{idle: 16'd0, hold: 16'(short_press), expected: disp_ops};
        rows[4] = '{idle: 16'd0, hold: 16'(short_press), expected: disp_cycles};
        rows[5] = '{idle: 16'd0, hold: 16'(short_press), expected: disp_plain};  // Wrap
        rows[6] = '{idle: 16'd0, hold: 16'(long_press), expected: disp_cipher};  // One step only

        repeat (reset_cycles) @(posedge clk_clk);
        #1;
        reset_reset_n = 1'b1;

        for (int r = 0; r < n_rows; r++) begin
            next_cycles(int'(rows[r].idle));
            if (rows[r].hold != 16'd0) begin
                press_button(int'(rows[r].hold));
            end
            next_cycles(settle_cycles);
            check_display(r);
        end

        $display("Result: PASSED");
        $finish;
    end

    // Watchdog
    initial begin
        #(run_cycles * clk_period);
        $display("Timeout: the stimulus table did not finish within %0d cycles", run_cycles);
        stop_on_error();
    end

endmodule

//--- design/cipher_top.sv
// Cipher top level
// Runs one key-times-word product after start-up and shows the word,
// the ciphertext or a performance counter on six seven-segment digits

`timescale 1ns/1ps

module cipher_top (
    input  logic                  clk_clk,
    input  logic                  reset_reset_n,
    input  logic                  mode_button,
    output cipher_pkg::display_t  hex
);
    import cipher_pkg::*;

    logic       start;
    logic       busy;
    logic       done;
    logic       show_ready;
    column_t    column;
    perf_t      perf;
    word_t      shown;
    disp_mode_t mode;

    cipher_sequencer i_sequencer (
        .clk_clk       (clk_clk),
        .reset_reset_n (reset_reset_n),
        .done          (done),
        .start         (start),
        .show_ready    (show_ready)
    );

    mac_column_array i_array (
        .clk_clk       (clk_clk),
        .reset_reset_n (reset_reset_n),
        .start         (start),
        .busy          (busy),
        .done          (done),
        .column        (column)
    );

    perf_counters i_perf (
        .clk_clk       (clk_clk),
        .reset_reset_n (reset_reset_n),
        .start         (start),
        .busy          (busy),
        .perf          (perf)
    );

    display_select i_select (
        .clk_clk       (clk_clk),
        .reset_reset_n (reset_reset_n),
        .mode_button   (mode_button),
        .show_ready    (show_ready),
        .done          (done),
        .column        (column),
        .perf          (perf),
        .shown         (shown),
        .mode          (mode)
    );

    seg_encoder i_encoder (
        .mode  (mode),
        .shown (shown),
        .hex   (hex)
    );

endmodule

//--- design/cipher_sequencer.sv
// Cipher sequencer
// Waits out the start-up delay, launches the single multiply and
// then holds in the showing phase until reset

`timescale 1ns/1ps

module cipher_sequencer (
    input  logic clk_clk,
    input  logic reset_reset_n,
    input  logic done,
    output logic start,
    output logic show_ready
);
    import cipher_pkg::*;

    typedef logic [$clog2(init_delay)-1:0] delay_t;

    phase_t phase;
    delay_t delay_cnt;
    logic   delay_done;

    // Last cycle of the start-up delay
    assign delay_done = (delay_cnt == delay_t'(init_delay - 1));

    // ----------------------------------------
    // Phase FSM
    // ----------------------------------------
    always_ff @(posedge clk_clk or negedge reset_reset_n) begin
        if (!reset_reset_n) begin
            phase     <= phase_init;
            delay_cnt <= '0;
            start     <= 1'b0;
        end else begin
            start <= 1'b0;  // Single-cycle pulse
            case (phase)
                phase_init: begin
                    if (delay_done) begin
                        phase <= phase_compute;
                        start <= 1'b1;  // High on first compute cycle
                    end else begin
                        delay_cnt <= delay_cnt + 1'b1;
                    end
                end

                phase_compute: begin
                    if (done) begin
                        phase <= phase_show;
                    end
                end

                // No way out except reset
                phase_show: phase <= phase_show;

                default: phase <= phase_init;
            endcase
        end
    end

    assign show_ready = (phase == phase_show);

endmodule

//--- design/mac_column_array.sv
// Multiply-accumulate column array
// Eight rows form the first column of key times plaintext,
// one column index k per busy cycle over mat_n cycles

`timescale 1ns/1ps

module mac_column_array (
    input  logic                 clk_clk,
    input  logic                 reset_reset_n,
    input  logic                 start,
    output logic                 busy,
    output logic                 done,
    output cipher_pkg::column_t  column
);
    import cipher_pkg::*;

    typedef logic [$clog2(mat_n)-1:0] step_t;

    step_t   step;                // Column index k
    logic    last_step;
    elem_t   plain_col [mat_n];   // Plaintext column, padded
    elem_t   key_elem  [mat_n];   // Key element (i, k) per row
    column_t acc;
    column_t acc_next;

    assign last_step = (step == step_t'(mat_n - 1));
    assign done      = busy && last_step;

    // ----------------------------------------
    // Plaintext column
    // ----------------------------------------
    for (genvar j = 0; j < mat_n; j++) begin : g_plain
        if (j < word_len) begin : g_letter
            assign plain_col[j] = elem_t'(plain_word.letter[j]);
        end else begin : g_pad
            assign plain_col[j] = elem_t'(j);  // Row number as padding
        end
    end

    // ----------------------------------------
    // Step control
    // ----------------------------------------
    always_ff @(posedge clk_clk or negedge reset_reset_n) begin
        if (!reset_reset_n) begin
            busy <= 1'b0;
            step <= '0;
        end else if (start) begin
            busy <= 1'b1;
            step <= '0;
        end else if (busy) begin
            step <= step + 1'b1;
            if (last_step) begin
                busy <= 1'b0;
            end
        end
    end

    // Diagonal key, so only row k gets a nonzero term
    always_comb begin
        acc_next = acc;
        for (int i = 0; i < mat_n; i++) begin
            key_elem[i] = (step == step_t'(i)) ? elem_t'(key_diag) : '0;
            if (start) begin
                acc_next.row[i] = '0;
            end else if (busy) begin
                acc_next.row[i] = acc.row[i]
                                + acc_t'(key_elem[i]) * acc_t'(plain_col[step]);
            end
        end
    end

    always_ff @(posedge clk_clk) begin
        acc <= acc_next;
    end

    // Final sums already visible during the done cycle
    assign column = acc_next;

endmodule

//--- design/perf_counters.sv
// Performance counters
// Arithmetic operations per launched multiply and cycles spent computing

`timescale 1ns/1ps

module perf_counters (
    input  logic               clk_clk,
    input  logic               reset_reset_n,
    input  logic               start,
    input  logic               busy,
    output cipher_pkg::perf_t  perf
);
    import cipher_pkg::*;

    // ----------------------------------------
    // Running totals, cleared by reset only
    // ----------------------------------------
    always_ff @(posedge clk_clk or negedge reset_reset_n) begin
        if (!reset_reset_n) begin
            perf.ops <= '0;
        end else if (start) begin
            perf.ops <= perf.ops + count_t'(ops_per_mult);  // Whole 8x8x8 product
        end
    end

    always_ff @(posedge clk_clk or negedge reset_reset_n) begin
        if (!reset_reset_n) begin
            perf.cycles <= '0;
        end else if (busy) begin
            perf.cycles <= perf.cycles + 1'b1;
        end
    end

endmodule

//--- design/display_select.sv
// Display selection
// Steps the display mode on button presses, captures the ciphertext
// and picks the value handed to the segment encoder

`timescale 1ns/1ps

module display_select (
    input  logic                    clk_clk,
    input  logic                    reset_reset_n,
    input  logic                    mode_button,
    input  logic                    show_ready,
    input  logic                    done,
    input  cipher_pkg::column_t     column,
    input  cipher_pkg::perf_t       perf,
    output cipher_pkg::word_t       shown,
    output cipher_pkg::disp_mode_t  mode
);
    import cipher_pkg::*;

    logic  btn_meta;
    logic  btn_sync;
    logic  btn_prev;
    logic  btn_edge;
    word_t cipher_word;

    // ----------------------------------------
    // Button sync and rising edge
    // ----------------------------------------
    always_ff @(posedge clk_clk or negedge reset_reset_n) begin
        if (!reset_reset_n) begin
            btn_meta <= 1'b0;
            btn_sync <= 1'b0;
            btn_prev <= 1'b0;
            btn_edge <= 1'b0;
        end else begin
            btn_meta <= mode_button;
            btn_sync <= btn_meta;
            btn_prev <= btn_sync;
            btn_edge <= btn_sync && !btn_prev;
        end
    end

    // Presses before the result is ready are dropped
    always_ff @(posedge clk_clk or negedge reset_reset_n) begin
        if (!reset_reset_n) begin
            mode <= mode_plain;
        end else if (btn_edge && show_ready) begin
            case (mode)
                mode_plain:  mode <= mode_cipher;
                mode_cipher: mode <= mode_ops;
                mode_ops:    mode <= mode_cycles;
                default:     mode <= mode_plain;
            endcase
        end
    end

    // Ciphertext is each product row modulo 26
    always_ff @(posedge clk_clk or negedge reset_reset_n) begin
        if (!reset_reset_n) begin
            cipher_word <= '0;
        end else if (done) begin
            for (int i = 0; i < word_len; i++) begin
                cipher_word.letter[i] <= char_t'(column.row[i] % alpha_n);
            end
        end
    end

    // ----------------------------------------
    // Shown value
    // ----------------------------------------
    always_comb begin
        case (mode)
            mode_plain:  shown = plain_word;
            mode_cipher: shown = cipher_word;
            mode_ops:    shown = word_t'({16'd0, perf.ops});
            default:     shown = word_t'({16'd0, perf.cycles});
        endcase
    end

endmodule

//--- design/seg_encoder.sv
// Seven-segment encoder
// Letters on all six digits, or four hex digits plus a two-letter tag

`timescale 1ns/1ps

module seg_encoder (
    input  cipher_pkg::disp_mode_t  mode,
    input  cipher_pkg::word_t       shown,
    output cipher_pkg::display_t    hex
);
    import cipher_pkg::*;

    // Letter index to segments, some letters borrow a close shape
    function automatic seg_t letter_seg(input char_t ch);
        case (ch)
            8'd0:    return 7'b0001000;  // A
            8'd1:    return 7'b0000011;  // b
            8'd2:    return 7'b1000110;  // C
            8'd3:    return 7'b0100001;  // d
            8'd4:    return 7'b0000110;  // E
            8'd5:    return 7'b0001110;  // F
            8'd6:    return 7'b1000010;  // G
            8'd7:    return 7'b0001001;  // H
            8'd8:    return 7'b1111001;  // I
            8'd9:    return 7'b1100001;  // J
            8'd10:   return 7'b0001001;  // K as H
            8'd11:   return 7'b1000111;  // L
            8'd12:   return 7'b1001000;  // M
            8'd13:   return 7'b1001000;  // N as M
            8'd14:   return 7'b1000000;  // O
            8'd15:   return 7'b0001100;  // P
            8'd16:   return 7'b0011000;  // q
            8'd17:   return 7'b0101111;  // r
            8'd18:   return 7'b0010010;  // S
            8'd19:   return 7'b0000111;  // t
            8'd20:   return 7'b1000001;  // U
            8'd21:   return 7'b1000001;  // V as U
            8'd22:   return 7'b1000001;  // W as U
            8'd23:   return 7'b0001001;  // X as H
            8'd24:   return 7'b0010001;  // Y
            8'd25:   return 7'b0100100;  // Z
            default: return 7'b1111111;  // Blank
        endcase
    endfunction

    function automatic seg_t hex_seg(input logic [3:0] nib);
        case (nib)
            4'h0:    return 7'b1000000;
            4'h1:    return 7'b1111001;
            4'h2:    return 7'b0100100;
            4'h3:    return 7'b0110000;
            4'h4:    return 7'b0011001;
            4'h5:    return 7'b0010010;
            4'h6:    return 7'b0000010;
            4'h7:    return 7'b1111000;
            4'h8:    return 7'b0000000;
            4'h9:    return 7'b0010000;
            4'hA:    return 7'b0001000;
            4'hB:    return 7'b0000011;
            4'hC:    return 7'b1000110;
            4'hD:    return 7'b0100001;
            4'hE:    return 7'b0000110;
            default: return 7'b0001110;  // F
        endcase
    endfunction

    always_comb begin
        hex = '1;  // All segments off
        case (mode)
            mode_plain, mode_cipher: begin
                for (int n = 0; n < word_len; n++) begin
                    hex.digit[n] = letter_seg(shown.letter[n]);
                end
            end

            default: begin
                // Low 16 bits, least significant nibble on hex0
                for (int n = 0; n < 4; n++) begin
                    hex.digit[n] = hex_seg(shown[4*n +: 4]);
                end
                if (mode == mode_ops) begin
                    hex.digit[4] = letter_seg(8'd14);  // O
                    hex.digit[5] = letter_seg(8'd15);  // P
                end else begin
                    hex.digit[4] = letter_seg(8'd2);   // C
                    hex.digit[5] = letter_seg(8'd2);   // C
                end
            end
        endcase
    end

endmodule

//--- design/cipher_pkg.sv
// Cipher package
// Shared widths, constants and types for the fixed-key matrix cipher
// and its seven-segment readout

package cipher_pkg;

    // ----------------------------------------
    // Sizes and constants
    // ----------------------------------------
    localparam int mat_n        = 8;    // Matrix order
    localparam int word_len     = 6;    // Letters in the word
    localparam int alpha_n      = 26;   // Alphabet size
    localparam int key_diag     = 5;    // Key matrix diagonal
    localparam int init_delay   = 100;  // Start-up cycles
    localparam int ops_per_mult = 512;  // mat_n cubed

    // ----------------------------------------
    // Scalar types
    // ----------------------------------------
    typedef logic signed [15:0] elem_t;   // Matrix element
    typedef logic signed [31:0] acc_t;    // Accumulator
    typedef logic        [7:0]  char_t;   // Letter index, A = 0
    typedef logic        [31:0] count_t;  // Performance counter
    typedef logic        [6:0]  seg_t;    // Active-low segments

    // ----------------------------------------
    // Grouped signals
    // ----------------------------------------

    // Letter 0 is shown on hex0
    typedef struct packed {
        char_t [word_len-1:0] letter;
    } word_t;

    // One result column of the product
    typedef struct packed {
        acc_t [mat_n-1:0] row;
    } column_t;

    typedef struct packed {
        count_t ops;     // Arithmetic operations
        count_t cycles;  // Compute cycles
    } perf_t;

    // Digit 0 drives hex0
    typedef struct packed {
        seg_t [word_len-1:0] digit;
    } display_t;

    typedef enum logic [1:0] {
        mode_plain,
        mode_cipher,
        mode_ops,
        mode_cycles
    } disp_mode_t;

    typedef enum logic [1:0] {
        phase_init,
        phase_compute,
        phase_show
    } phase_t;

    // CIPHER, C on letter 0
    localparam word_t plain_word = '{letter: {8'd17, 8'd4, 8'd7, 8'd15, 8'd8, 8'd2}};

endpackage
